/* logic/sw_pkg.sv */
package sw_pkg;

    // ----------------------------------------
    // sequence sizes
    // ----------------------------------------
    localparam int REF_LEN   = 64;
    localparam int QUERY_LEN = 16;

    // plain vector types
    typedef logic [1:0]                   base_t;
    typedef logic signed [7:0]            score_t;
    typedef logic [6:0]                   ref_pos_t;
    typedef logic [5:0]                   query_pos_t;
    typedef logic [$clog2(REF_LEN)-1:0]   ref_addr_t;
    typedef logic [$clog2(QUERY_LEN)-1:0] pe_idx_t;

    // ----------------------------------------
    // scoring constants
    // ----------------------------------------
    localparam score_t MATCH_SCORE    = 8'sd2;
    localparam score_t MISMATCH_SCORE = -8'sd1;
    localparam score_t GAP_OPEN       = 8'sd2;
    localparam score_t GAP_EXTEND     = 8'sd1;
    // boundary value of the gap scores, stands for minus infinity
    localparam score_t NEG_INF        = -8'sd8;

    typedef struct packed {
        score_t     score;
        ref_pos_t   ref_pos;
        query_pos_t query_pos;
    } best_t;

    // one reference row travelling from element to element
    typedef struct packed {
        logic     valid;
        logic     first;
        base_t    base;
        ref_pos_t ref_pos;
        score_t   high;
        score_t   del;
    } pe_link_t;

    typedef enum logic [2:0] {IDLE, LOAD, STREAM, DRAIN, REDUCE} ctrl_state_t;

    function automatic score_t max_score(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

endpackage

/* logic/seq_buffer.sv */
`timescale 1ns/1ps

module seq_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load_en_i,
    input  logic                                valid_i,
    input  sw_pkg::ref_addr_t                   wr_addr_i,
    input  sw_pkg::base_t                       data_ref_i,
    input  sw_pkg::base_t                       data_query_i,
    input  sw_pkg::ref_addr_t                   rd_addr_i,
    output sw_pkg::base_t                       ref_base_o,
    output sw_pkg::base_t [sw_pkg::QUERY_LEN-1:0] query_o
);
    import sw_pkg::*;

    base_t                 ref_mem [REF_LEN];
    base_t [QUERY_LEN-1:0] query_q;
    logic                  wr_en;

    assign wr_en = load_en_i && valid_i;

    // ----------------------------------------
    // reference memory
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ref_mem[wr_addr_i] <= data_ref_i;
        end
    end

    // streamed out one row per cycle
    assign ref_base_o = ref_mem[rd_addr_i];

    // ----------------------------------------
    // query register
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            query_q <= '0;
        end else if (wr_en && (wr_addr_i < QUERY_LEN)) begin
            // only the first QUERY_LEN bases belong to the query
            query_q[pe_idx_t'(wr_addr_i)] <= data_query_i;
        end
    end

    assign query_o = query_q;

endmodule

/* logic/fill_ctrl.sv */
`timescale 1ns/1ps

module fill_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_i,
    input  sw_pkg::base_t     ref_base_i,
    output logic              load_en_o,
    output sw_pkg::ref_addr_t wr_addr_o,
    output sw_pkg::ref_addr_t rd_addr_o,
    output logic              job_start_o,
    output sw_pkg::pe_link_t  link_o,
    output logic              reduce_en_o,
    output sw_pkg::pe_idx_t   reduce_idx_o,
    output logic              finish_o
);
    import sw_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t next_state;
    ref_addr_t   cnt_q;
    ref_addr_t   next_cnt;
    logic        finish_q;
    logic        next_finish;

    // ----------------------------------------
    // next state and shared counter
    // ----------------------------------------
    always_comb begin
        next_state  = state_q;
        next_cnt    = cnt_q;
        next_finish = 1'b0;
        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    next_cnt   = cnt_q + 1'b1;
                    next_state = LOAD;
                end
            end
            LOAD: begin
                // gaps in valid_i just pause the count
                if (valid_i) begin
                    next_cnt = (cnt_q == REF_LEN - 1) ? '0 : cnt_q + 1'b1;
                    if (cnt_q == REF_LEN - 1) begin
                        next_state = STREAM;
                    end
                end
            end
            STREAM: begin
                next_cnt = (cnt_q == REF_LEN - 1) ? '0 : cnt_q + 1'b1;
                if (cnt_q == REF_LEN - 1) begin
                    next_state = DRAIN;
                end
            end
            DRAIN, REDUCE: begin
                next_cnt = (cnt_q == QUERY_LEN - 1) ? '0 : cnt_q + 1'b1;
                if (cnt_q == QUERY_LEN - 1) begin
                    next_state  = (state_q == DRAIN) ? REDUCE : IDLE;
                    next_finish = (state_q == REDUCE);
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q  <= IDLE;
            cnt_q    <= '0;
            finish_q <= 1'b0;
        end else begin
            state_q  <= next_state;
            cnt_q    <= next_cnt;
            finish_q <= next_finish;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign load_en_o    = (state_q == IDLE) || (state_q == LOAD);
    assign wr_addr_o    = cnt_q;
    assign rd_addr_o    = cnt_q;
    assign job_start_o  = (state_q == IDLE) && valid_i;
    assign reduce_en_o  = (state_q == REDUCE);
    assign reduce_idx_o = pe_idx_t'(cnt_q);
    assign finish_o     = finish_q;

    // row feed into element 0, column 0 is the boundary
    always_comb begin
        link_o = '0;
        if (state_q == STREAM) begin
            link_o.valid   = 1'b1;
            link_o.first   = (cnt_q == '0);
            link_o.base    = ref_base_i;
            link_o.ref_pos = ref_pos_t'(cnt_q) + 7'd1;
            link_o.high    = '0;
            link_o.del     = NEG_INF;
        end
    end

endmodule

/* logic/sw_pe.sv */
`timescale 1ns/1ps

module sw_pe (
    input  logic               clk,
    input  logic               reset,
    input  logic               clear_i,
    input  sw_pkg::base_t      query_base_i,
    input  sw_pkg::query_pos_t query_pos_i,
    input  sw_pkg::pe_link_t   link_i,
    output sw_pkg::pe_link_t   link_o,
    output sw_pkg::best_t      best_o
);
    import sw_pkg::*;

    // column state left behind by the previous row
    score_t   high_up_q;
    score_t   ins_up_q;
    score_t   high_diag_q;
    pe_link_t link_q;
    best_t    best_q;

    score_t   upper_high;
    score_t   upper_ins;
    score_t   diag_high;
    score_t   sub_score;
    score_t   ins_new;
    score_t   del_new;
    score_t   high_new;

    // ----------------------------------------
    // affine-gap cell recurrence
    // ----------------------------------------
    always_comb begin
        // row 1 sees the row 0 boundary above it
        if (link_i.first) begin
            upper_high = '0;
            upper_ins  = NEG_INF;
            diag_high  = '0;
        end else begin
            upper_high = high_up_q;
            upper_ins  = ins_up_q;
            diag_high  = high_diag_q;
        end
        sub_score = (link_i.base == query_base_i) ? MATCH_SCORE : MISMATCH_SCORE;
        ins_new   = max_score(upper_high - GAP_OPEN, upper_ins - GAP_EXTEND);
        del_new   = max_score(link_i.high - GAP_OPEN, link_i.del - GAP_EXTEND);
        // local alignment, never below zero
        high_new  = max_score(max_score(diag_high + sub_score, ins_new),
                              max_score(del_new, score_t'(0)));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            high_up_q   <= '0;
            ins_up_q    <= NEG_INF;
            high_diag_q <= '0;
            link_q      <= '0;
            best_q      <= '0;
        end else if (clear_i) begin
            high_up_q   <= '0;
            ins_up_q    <= NEG_INF;
            high_diag_q <= '0;
            link_q      <= '0;
            best_q      <= '0;
        end else if (link_i.valid) begin
            high_up_q      <= high_new;
            ins_up_q       <= ins_new;
            high_diag_q    <= link_i.high;
            link_q.valid   <= 1'b1;
            link_q.first   <= link_i.first;
            link_q.base    <= link_i.base;
            link_q.ref_pos <= link_i.ref_pos;
            link_q.high    <= high_new;
            link_q.del     <= del_new;
            // strictly greater, earliest row keeps a tie
            if (high_new > best_q.score) begin
                best_q.score     <= high_new;
                best_q.ref_pos   <= link_i.ref_pos;
                best_q.query_pos <= query_pos_i;
            end
        end else begin
            link_q.valid <= 1'b0;
        end
    end

    assign link_o = link_q;
    assign best_o = best_q;

endmodule

/* logic/pe_array.sv */
`timescale 1ns/1ps

module pe_array (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear_i,
    input  sw_pkg::base_t [sw_pkg::QUERY_LEN-1:0] query_i,
    input  sw_pkg::pe_link_t                      link_i,
    output sw_pkg::best_t [sw_pkg::QUERY_LEN-1:0] best_o
);
    import sw_pkg::*;

    // links[k] feeds element k, the last one is left open
    pe_link_t links [QUERY_LEN+1];

    assign links[0] = link_i;

    // ----------------------------------------
    // processing element chain
    // ----------------------------------------
    for (genvar k = 0; k < QUERY_LEN; k++) begin : g_pe
        sw_pe u_pe (
            .clk          (clk),
            .reset        (reset),
            .clear_i      (clear_i),
            .query_base_i (query_i[k]),
            .query_pos_i  (query_pos_t'(k + 1)),
            .link_i       (links[k]),
            .link_o       (links[k+1]),
            .best_o       (best_o[k])
        );
    end

endmodule

/* logic/max_reduce.sv */
`timescale 1ns/1ps

module max_reduce (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear_i,
    input  logic                                  reduce_en_i,
    input  sw_pkg::pe_idx_t                       reduce_idx_i,
    input  sw_pkg::best_t [sw_pkg::QUERY_LEN-1:0] pe_best_i,
    output sw_pkg::best_t                         best_o
);
    import sw_pkg::*;

    best_t work_q;
    best_t best_q;
    best_t sel_best;
    best_t pick;

    // ----------------------------------------
    // serial compare
    // ----------------------------------------
    assign sel_best = pe_best_i[reduce_idx_i];
    // lower element index wins a tie
    assign pick = (sel_best.score > work_q.score) ? sel_best : work_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            work_q <= '0;
            best_q <= '0;
        end else if (clear_i) begin
            work_q <= '0;
        end else if (reduce_en_i) begin
            work_q <= pick;
            // last element, result goes out with finish
            if (reduce_idx_i == QUERY_LEN - 1) begin
                best_q <= pick;
            end
        end
    end

    // held until the next job's reduce
    assign best_o = best_q;

endmodule

/* logic/sw_top.sv */
`timescale 1ns/1ps

module sw_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          valid_i,
    input  sw_pkg::base_t data_ref_i,
    input  sw_pkg::base_t data_query_i,
    output logic          finish_o,
    output sw_pkg::best_t best_o
);
    import sw_pkg::*;

    logic                  load_en;
    ref_addr_t             wr_addr;
    ref_addr_t             rd_addr;
    base_t                 ref_base;
    base_t [QUERY_LEN-1:0] query;
    logic                  job_start;
    pe_link_t              link;
    best_t [QUERY_LEN-1:0] pe_best;
    logic                  reduce_en;
    pe_idx_t               reduce_idx;

    seq_buffer u_seq_buffer (
        .clk(clk), .reset(reset), .load_en_i(load_en), .valid_i(valid_i),
        .wr_addr_i(wr_addr), .data_ref_i(data_ref_i), .data_query_i(data_query_i),
        .rd_addr_i(rd_addr), .ref_base_o(ref_base), .query_o(query)
    );

    fill_ctrl u_fill_ctrl (
        .clk(clk), .reset(reset), .valid_i(valid_i), .ref_base_i(ref_base),
        .load_en_o(load_en), .wr_addr_o(wr_addr), .rd_addr_o(rd_addr),
        .job_start_o(job_start), .link_o(link), .reduce_en_o(reduce_en),
        .reduce_idx_o(reduce_idx), .finish_o(finish_o)
    );

    pe_array u_pe_array (
        .clk(clk), .reset(reset), .clear_i(job_start), .query_i(query),
        .link_i(link), .best_o(pe_best)
    );

    max_reduce u_max_reduce (
        .clk(clk), .reset(reset), .clear_i(job_start), .reduce_en_i(reduce_en),
        .reduce_idx_i(reduce_idx), .pe_best_i(pe_best), .best_o(best_o)
    );

endmodule

/* verification/sw_props.sv */
`timescale 1ns/1ps

module sw_props (
    input logic          clk,
    input logic          reset,
    input logic          finish_i,
    input sw_pkg::best_t best_i
);
    import sw_pkg::*;

    // ----------------------------------------
    // finish protocol
    // ----------------------------------------
    finish_single: assert property (@(posedge clk) disable iff (reset)
        finish_i |=> !finish_i)
        else $error("finish_o stayed high for two cycles");

    // result moves only on the edge that raises finish
    best_held: assert property (@(posedge clk) disable iff (reset)
        !$stable(best_i) |-> finish_i)
        else $error("best_o changed outside the finish cycle");

    // ----------------------------------------
    // result contents
    // ----------------------------------------
    score_range: assert property (@(posedge clk) disable iff (reset)
        best_i.score >= 0 && best_i.score <= MATCH_SCORE * QUERY_LEN)
        else $error("best_o.score %0d outside the reachable range", best_i.score);

    zero_no_pos: assert property (@(posedge clk) disable iff (reset)
        best_i.score == 0 |-> best_i.ref_pos == 0 && best_i.query_pos == 0)
        else $error("best_o has a zero score with nonzero positions");

endmodule

bind sw_top sw_props u_sw_props (
    .clk(clk), .reset(reset), .finish_i(finish_o), .best_i(best_o)
);

/* verification/tb_sw.sv */
`timescale 1ns/1ps

module tb_sw;
    import sw_pkg::*;

    localparam int FINISH_TIMEOUT = 400;
    localparam int LOAD_TIMEOUT   = 400;

    logic   clk;
    logic   reset;
    logic   valid_i;
    base_t  data_ref_i;
    base_t  data_query_i;
    logic   finish_o;
    best_t  best_o;

    integer seed = 32'h5d84;
    int     errors;
    int     checks;
    int     timeouts;
    best_t  held_best;
    best_t  exp_best;
    base_t  ref_seq [REF_LEN];
    base_t  query_seq [QUERY_LEN];

    sw_top dut_i (
        .clk(clk), .reset(reset), .valid_i(valid_i), .data_ref_i(data_ref_i),
        .data_query_i(data_query_i), .finish_o(finish_o), .best_o(best_o)
    );

    always #10 clk = ~clk;

    function automatic base_t rand_base();
        return base_t'($random(seed));
    endfunction

    function automatic int imax(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // ----------------------------------------
    // reference model over the full score matrix
    // ----------------------------------------
    task automatic compute_expected(output best_t result);
        int h   [REF_LEN+1][QUERY_LEN+1];
        int ins [REF_LEN+1][QUERY_LEN+1];
        int del [REF_LEN+1][QUERY_LEN+1];
        int sub;
        int best_score;
        int best_row;
        int best_col;
        for (int j = 0; j <= QUERY_LEN; j++) begin
            h[0][j]   = 0;
            ins[0][j] = NEG_INF;
        end
        for (int i = 0; i <= REF_LEN; i++) begin
            h[i][0]   = 0;
            del[i][0] = NEG_INF;
        end
        for (int i = 1; i <= REF_LEN; i++) begin
            for (int j = 1; j <= QUERY_LEN; j++) begin
                ins[i][j] = imax(h[i-1][j] - GAP_OPEN, ins[i-1][j] - GAP_EXTEND);
                del[i][j] = imax(h[i][j-1] - GAP_OPEN, del[i][j-1] - GAP_EXTEND);
                sub = (ref_seq[i-1] == query_seq[j-1]) ? MATCH_SCORE : MISMATCH_SCORE;
                h[i][j] = imax(imax(0, h[i-1][j-1] + sub), imax(ins[i][j], del[i][j]));
            end
        end
        // lowest query position first, then lowest reference position
        best_score = 0;
        best_row   = 0;
        best_col   = 0;
        for (int j = 1; j <= QUERY_LEN; j++) begin
            for (int i = 1; i <= REF_LEN; i++) begin
                if (h[i][j] > best_score) begin
                    best_score = h[i][j];
                    best_row   = i;
                    best_col   = j;
                end
            end
        end
        result.score     = score_t'(best_score);
        result.ref_pos   = ref_pos_t'(best_row);
        result.query_pos = query_pos_t'(best_col);
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_best(input best_t expected, input string what);
        checks++;
        assert (best_o == expected) else begin
            errors++;
            // values are score/ref_pos/query_pos
            $display("ERR %0t best_o (%s) expected %0d/%0d/%0d got %0d/%0d/%0d",
                     $time, what,
                     expected.score, expected.ref_pos, expected.query_pos,
                     best_o.score, best_o.ref_pos, best_o.query_pos);
        end
    endtask

    task automatic check_score(input int expected, input string what);
        checks++;
        assert (best_o.score == expected) else begin
            errors++;
            $display("ERR %0t best_o.score (%s) expected %0d got %0d", $time, what,
                     expected, best_o.score);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic random_seqs();
        foreach (ref_seq[i]) ref_seq[i] = rand_base();
        foreach (query_seq[j]) query_seq[j] = rand_base();
    endtask

    // query copied from the reference window at 10 with extra bases at index 8
    task automatic make_gapped_query(input int extra);
        for (int j = 0; j < QUERY_LEN; j++) begin
            if (j < 8) begin
                query_seq[j] = ref_seq[10 + j];
            end else if (j < 8 + extra) begin
                query_seq[j] = ~ref_seq[18];
            end else begin
                query_seq[j] = ref_seq[10 + j - extra];
            end
        end
    endtask

    task automatic load_job(input int gap_pct);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < REF_LEN && cycles < LOAD_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if ({$random(seed)} % 100 < gap_pct) begin
                valid_i      <= 1'b0;
                data_ref_i   <= rand_base();
                data_query_i <= rand_base();
            end else begin
                valid_i      <= 1'b1;
                data_ref_i   <= ref_seq[idx];
                data_query_i <= (idx < QUERY_LEN) ? query_seq[idx] : rand_base();
                idx++;
            end
            @(negedge clk);
            check_best(held_best, "held during load");
        end
        if (idx < REF_LEN) begin
            timeouts++;
            $display("timeout: only %0d of %0d bases were loaded", idx, REF_LEN);
        end
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    // strobes that the engine must ignore while busy
    task automatic busy_pulses(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i      <= 1'($random(seed));
            data_ref_i   <= rand_base();
            data_query_i <= rand_base();
        end
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    task automatic wait_finish(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < FINISH_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (finish_o) begin
                seen = 1'b1;
            end else begin
                check_best(held_best, "held until finish");
            end
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: finish_o did not pulse within %0d cycles", FINISH_TIMEOUT);
        end
    endtask

    task automatic run_job(input int gap_pct, input int noise, input string what);
        bit seen;
        compute_expected(exp_best);
        load_job(gap_pct);
        if (noise > 0) begin
            busy_pulses(noise);
        end
        wait_finish(seen);
        if (seen) begin
            check_best(exp_best, what);
        end
        held_best = best_o;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        valid_i      = 1'b0;
        data_ref_i   = '0;
        data_query_i = '0;
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        held_best    = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_best('0, "after reset");
        checks++;
        assert (!finish_o) else begin
            errors++;
            $display("ERR %0t finish_o expected 0 got %0b", $time, finish_o);
        end

        // query embedded at reference position 30
        random_seqs();
        for (int j = 0; j < QUERY_LEN; j++) begin
            ref_seq[29 + j] = query_seq[j];
        end
        run_job(0, 0, "exact embedding");
        check_best(best_t'{score: 8'sd32, ref_pos: 7'd45, query_pos: 6'd16}, "embedding");

        foreach (ref_seq[i]) ref_seq[i] = 2'd0;
        foreach (query_seq[j]) query_seq[j] = 2'd1;
        run_job(0, 0, "no match");
        check_best('0, "no match zero");

        // one gap opened, then a gap opened and extended
        random_seqs();
        make_gapped_query(1);
        run_job(0, 0, "single insert");
        check_score(28, "single insert");
        random_seqs();
        make_gapped_query(2);
        run_job(0, 0, "double insert");
        check_score(25, "double insert");

        repeat (8) begin
            random_seqs();
            run_job(0, 0, "random job");
        end

        repeat (2) begin
            random_seqs();
            run_job(30, 40, "irregular valid");
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
logic/sw_pkg.sv
logic/seq_buffer.sv
logic/fill_ctrl.sv
logic/sw_pe.sv
logic/pe_array.sv
logic/max_reduce.sv
logic/sw_top.sv
verification/sw_props.sv
verification/tb_sw.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the Smith-Waterman testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_sw -o sim_tb_sw

./obj_dir/sim_tb_sw 2>&1 | tee "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
